//--- Makefile
# Verilator build and run of the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= branch_predictor_tb
FILELIST  ?= branch_predictor.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF -- "$(PASS_MSG)" $(LOG) && ! grep -q "%Error" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- bp_cfg.svh
/*
 branch predictor configuration
 table geometry and chooser score width shared by the
 target buffer, the direction predictor and the package
*/
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// index bits, taken from fetch address bits 8..3
`define BP_INDEX_W 6

// tag bits, directly above the index
`define BP_TAG_W 8

// tournament chooser score
// resets to the midpoint value 4
`define BP_SCORE_W 3

`endif

//--- branch_predictor.f
+incdir+.
hdl/bp_pkg.sv
hdl/bp_table.sv
hdl/bp_target_buffer.sv
hdl/bp_direction.sv
hdl/branch_predictor.sv
verification/tb_clock.sv
verification/branch_predictor_assert.sv
verification/branch_predictor_tb.sv

//--- hdl/bp_direction.sv
/*
 tournament direction predictor
 bimodal counters indexed by address, history counters
 indexed by address xor global history, and a saturating
 chooser score that picks between them
*/
`timescale 1ns/10ps
`include "bp_cfg.svh"

module bp_direction (
    input  logic               clk,
    input  logic               rstn,
    input  logic [31:0]        fetch_pc,
    input  bp_pkg::bp_update_t upd,
    output logic               taken
);

    localparam int                      IDX_LO     = 3;
    localparam bp_pkg::ctr_t            CTR_WEAK_T = 2'd2;
    localparam logic [`BP_SCORE_W-1:0]  SCORE_INIT = 1 << (`BP_SCORE_W - 1);
    localparam logic [`BP_SCORE_W-1:0]  SCORE_MAX  = '1;

    logic [`BP_INDEX_W-1:0] ghr;
    logic [`BP_SCORE_W-1:0] score;

    logic [`BP_INDEX_W-1:0] fetch_idx;
    logic [`BP_INDEX_W-1:0] fetch_hidx;
    logic [`BP_INDEX_W-1:0] upd_idx;
    logic [`BP_INDEX_W-1:0] upd_hidx;

    bp_pkg::ctr_t bim_look;
    bp_pkg::ctr_t hist_look;
    bp_pkg::ctr_t bim_old;
    bp_pkg::ctr_t hist_old;
    bp_pkg::ctr_t bim_new;
    bp_pkg::ctr_t hist_new;

    logic train;
    logic bim_pred;
    logic hist_pred;

    // one step toward the outcome, saturating at 0 and 3
    function automatic bp_pkg::ctr_t ctr_step(input bp_pkg::ctr_t c, input logic t);
        if (t) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    assign fetch_idx  = fetch_pc[IDX_LO+`BP_INDEX_W-1:IDX_LO];
    assign upd_idx    = upd.pc[IDX_LO+`BP_INDEX_W-1:IDX_LO];
    // history hash uses the history before this update
    assign fetch_hidx = fetch_idx ^ ghr;
    assign upd_hidx   = upd_idx ^ ghr;

    // only conditional branches train
    assign train = upd.valid && (upd.btype == bp_pkg::BT_COND);

    // port a for lookup, port b reads the counter being trained
    bp_table #(
        .entry_t (bp_pkg::ctr_t),
        .rst_val (CTR_WEAK_T)
    ) u_bim_table (
        .clk     (clk),
        .rstn    (rstn),
        .raddr_a (fetch_idx),
        .rdata_a (bim_look),
        .raddr_b (upd_idx),
        .rdata_b (bim_old),
        .we      (train),
        .waddr   (upd_idx),
        .wdata   (bim_new)
    );

    bp_table #(
        .entry_t (bp_pkg::ctr_t),
        .rst_val (CTR_WEAK_T)
    ) u_hist_table (
        .clk     (clk),
        .rstn    (rstn),
        .raddr_a (fetch_hidx),
        .rdata_a (hist_look),
        .raddr_b (upd_hidx),
        .rdata_b (hist_old),
        .we      (train),
        .waddr   (upd_hidx),
        .wdata   (hist_new)
    );

    assign bim_new  = ctr_step(bim_old, upd.taken);
    assign hist_new = ctr_step(hist_old, upd.taken);

    // upper half of the score trusts the history table
    assign taken = score[`BP_SCORE_W-1] ? hist_look[1] : bim_look[1];

    // what each table said for the branch now resolving
    assign bim_pred  = bim_old[1];
    assign hist_pred = hist_old[1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ghr   <= '0;
            score <= SCORE_INIT;
        end else if (train) begin
            // newest outcome enters at bit 0
            ghr <= {ghr[`BP_INDEX_W-2:0], upd.taken};
            // score only moves when the tables disagreed
            if (bim_pred != hist_pred) begin
                if (hist_pred == upd.taken) begin
                    if (score != SCORE_MAX) begin
                        score <= score + 1'b1;
                    end
                end else if (score != '0) begin
                    score <= score - 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/bp_pkg.sv
/*
 branch predictor types
 branch type and prediction kind encodings, the target
 buffer entry, the direction counter and the structs
 exchanged with the fetch and execute stages
*/
`include "bp_cfg.svh"

package bp_pkg;

    // branch type as reported by execute
    // indirect is unconditional as well
    typedef enum logic [1:0] {
        BT_NONE     = 2'b00,
        BT_DIRECT   = 2'b01,
        BT_COND     = 2'b10,
        BT_INDIRECT = 2'b11
    } btype_e;

    // prediction kind towards fetch
    // 11 is never produced
    typedef enum logic [1:0] {
        PK_NOT_TAKEN = 2'b00,
        PK_UNCOND    = 2'b01,
        PK_COND      = 2'b10
    } pred_kind_e;

    // one target buffer entry
    typedef struct packed {
        logic                 valid;
        logic [`BP_TAG_W-1:0] tag;
        btype_e               btype;
        logic [31:0]          target;
    } btb_entry_t;

    // 2-bit saturating counter, 2 and 3 mean taken
    typedef logic [1:0] ctr_t;

    // resolved branch from execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        btype_e      btype;
        logic        taken;
    } bp_update_t;

    // prediction back to fetch
    typedef struct packed {
        logic [31:0] pc;
        pred_kind_e  kind;
    } bp_pred_t;

endpackage

//--- hdl/bp_table.sv
/*
 predictor table
 direct-mapped register array with a type parameter for
 the entry, two asynchronous read ports and one write port,
 every entry loads rst_val on reset
*/
`timescale 1ns/10ps
`include "bp_cfg.svh"

module bp_table #(
    parameter type    entry_t = logic [1:0],
    parameter entry_t rst_val = entry_t'(0)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`BP_INDEX_W-1:0] raddr_a,
    output entry_t                 rdata_a,
    input  logic [`BP_INDEX_W-1:0] raddr_b,
    output entry_t                 rdata_b,
    input  logic                   we,
    input  logic [`BP_INDEX_W-1:0] waddr,
    input  entry_t                 wdata
);

    localparam int DEPTH = 1 << `BP_INDEX_W;

    entry_t mem [DEPTH];

    // lookups answer in the same cycle
    // a write in this cycle shows from the next one
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // whole table back to its start state
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= rst_val;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

//--- hdl/bp_target_buffer.sv
/*
 branch target buffer
 tagged direct-mapped store of branch type and target for
 every taken branch, looked up combinationally with the
 fetch address and rewritten by taken updates
*/
`timescale 1ns/10ps
`include "bp_cfg.svh"

module bp_target_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic [31:0]        fetch_pc,
    input  bp_pkg::bp_update_t upd,
    output logic               hit,
    output bp_pkg::btype_e     btype,
    output logic [31:0]        target
);

    localparam int IDX_LO = 3;
    localparam int TAG_LO = IDX_LO + `BP_INDEX_W;

    logic [`BP_INDEX_W-1:0] fetch_idx;
    logic [`BP_TAG_W-1:0]   fetch_tag;
    logic [`BP_INDEX_W-1:0] upd_idx;
    bp_pkg::btb_entry_t     rd_entry;
    bp_pkg::btb_entry_t     wr_entry;
    logic                   wr_en;

    // index sits above the 8-byte fetch pair, tag right above it
    assign fetch_idx = fetch_pc[TAG_LO-1:IDX_LO];
    assign fetch_tag = fetch_pc[TAG_LO+`BP_TAG_W-1:TAG_LO];
    assign upd_idx   = upd.pc[TAG_LO-1:IDX_LO];

    // taken branches only, not-taken ones keep the old entry
    assign wr_en = upd.valid && upd.taken;

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = upd.pc[TAG_LO+`BP_TAG_W-1:TAG_LO];
        wr_entry.btype  = upd.btype;
        wr_entry.target = upd.target;
    end

    // second read port is not needed here
    bp_table #(
        .entry_t (bp_pkg::btb_entry_t),
        .rst_val ('0)
    ) u_btb_table (
        .clk     (clk),
        .rstn    (rstn),
        .raddr_a (fetch_idx),
        .rdata_a (rd_entry),
        .raddr_b (upd_idx),
        .rdata_b (),
        .we      (wr_en),
        .waddr   (upd_idx),
        .wdata   (wr_entry)
    );

    // valid and tag match
    assign hit    = rd_entry.valid && (rd_entry.tag == fetch_tag);
    assign btype  = rd_entry.btype;
    assign target = rd_entry.target;

endmodule

//--- hdl/branch_predictor.sv
/*
 branch prediction unit
 combines the target buffer and the tournament direction
 predictor into a next fetch address and prediction kind,
 answered in the cycle of the lookup
*/
`timescale 1ns/10ps

module branch_predictor (
    input  logic               clk,
    input  logic               rstn,
    input  logic [31:0]        fetch_pc,
    input  bp_pkg::bp_update_t upd,
    output bp_pkg::bp_pred_t   pred
);

    logic               btb_hit;
    bp_pkg::btype_e     btb_btype;
    logic [31:0]        btb_target;
    logic               dir_taken;
    logic [31:0]        fall_pc;
    bp_pkg::pred_kind_e kind;

    bp_target_buffer u_target_buffer (
        .clk      (clk),
        .rstn     (rstn),
        .fetch_pc (fetch_pc),
        .upd      (upd),
        .hit      (btb_hit),
        .btype    (btb_btype),
        .target   (btb_target)
    );

    bp_direction u_direction (
        .clk      (clk),
        .rstn     (rstn),
        .fetch_pc (fetch_pc),
        .upd      (upd),
        .taken    (dir_taken)
    );

    // two instructions per fetch
    // an odd-word start only carries one
    assign fall_pc = fetch_pc[2] ? fetch_pc + 32'd4 : fetch_pc + 32'd8;

    always_comb begin
        kind = bp_pkg::PK_NOT_TAKEN;
        if (btb_hit) begin
            case (btb_btype)
                bp_pkg::BT_DIRECT,
                bp_pkg::BT_INDIRECT: kind = bp_pkg::PK_UNCOND;
                // conditional needs the direction vote
                bp_pkg::BT_COND: begin
                    if (dir_taken) begin
                        kind = bp_pkg::PK_COND;
                    end
                end
                default: kind = bp_pkg::PK_NOT_TAKEN;
            endcase
        end
    end

    // target only when something is predicted taken
    assign pred.kind = kind;
    assign pred.pc   = (kind != bp_pkg::PK_NOT_TAKEN) ? btb_target : fall_pc;

endmodule

//--- verification/branch_predictor_assert.sv
/*
 branch predictor assertions
 checks the prediction kind encoding, the fall-through
 address on not-taken predictions and known outputs
*/
`timescale 1ns/10ps

module branch_predictor_assert (
    input logic             clk,
    input logic             rstn,
    input logic [31:0]      fetch_pc,
    input bp_pkg::bp_pred_t pred
);

    logic [31:0] fall_pc;

    // number of assertion failures so far
    int n_fail = 0;

    // one instruction left when the fetch starts on the odd word
    assign fall_pc = fetch_pc[2] ? fetch_pc + 32'd4 : fetch_pc + 32'd8;

    kind_legal: assert property (@(posedge clk) disable iff (!rstn)
        pred.kind != 2'b11)
        else begin
            n_fail++;
            $error("prediction kind 11 was produced");
        end

    fall_through: assert property (@(posedge clk) disable iff (!rstn)
        (pred.kind == bp_pkg::PK_NOT_TAKEN) |-> (pred.pc == fall_pc))
        else begin
            n_fail++;
            $error("not-taken prediction does not point to the fall-through address");
        end

    pred_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(pred))
        else begin
            n_fail++;
            $error("prediction holds unknown bits after reset");
        end

endmodule

bind branch_predictor branch_predictor_assert u_assert (.*);

//--- verification/branch_predictor_tb.sv
/*
 branch predictor testbench
 directed and random fetch and update phases, a reference
 model of target entries, counter tables, history and score,
 and a compare process that checks every cycle against it
*/
`timescale 1ns/10ps
`include "bp_cfg.svh"

module branch_predictor_tb;

    localparam int IDX_LO    = 3;
    localparam int TAG_LO    = IDX_LO + `BP_INDEX_W;
    localparam int DEPTH     = 1 << `BP_INDEX_W;
    localparam int SCORE_HI  = (1 << `BP_SCORE_W) - 1;
    localparam int SCORE_MID = 1 << (`BP_SCORE_W - 1);
    localparam int N_LOOK    = 24;
    localparam int N_MIX     = 500;
    // reset, both lookup phases, the mix and the directed phases
    localparam int N_CYCLES  = 8 + 2 * N_LOOK + N_MIX + 30;
    localparam int WATCHDOG_NS = (N_CYCLES + 100) * 100;
    localparam bp_pkg::bp_update_t NO_UPD = '0;

    logic               clk;
    logic               rstn;
    logic               rst_req;
    logic [31:0]        fetch_pc;
    bp_pkg::bp_update_t upd;
    bp_pkg::bp_pred_t   pred;
    integer             seed;
    int                 n_errors;
    int                 n_checks;

    // reference model state
    bp_pkg::btb_entry_t     ref_btb [DEPTH];
    bp_pkg::ctr_t           ref_bim [DEPTH];
    bp_pkg::ctr_t           ref_hist [DEPTH];
    logic [`BP_INDEX_W-1:0] ref_ghr;
    int                     ref_score;

    tb_clock u_tb_clock (
        .rst_req (rst_req),
        .clk     (clk),
        .rstn    (rstn)
    );

    branch_predictor u_branch_predictor (
        .clk      (clk),
        .rstn     (rstn),
        .fetch_pc (fetch_pc),
        .upd      (upd),
        .pred     (pred)
    );

    function automatic bp_pkg::ctr_t ctr_move(input bp_pkg::ctr_t c, input logic t);
        if (t && c != 2'd3) begin
            return c + 2'd1;
        end else if (!t && c != 2'd0) begin
            return c - 2'd1;
        end
        return c;
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < DEPTH; i++) begin
            ref_btb[i]  = '0;
            ref_bim[i]  = 2'd2;
            ref_hist[i] = 2'd2;
        end
        ref_ghr   = '0;
        ref_score = SCORE_MID;
    endfunction

    // one resolved branch applied to the model
    function automatic void train_model(input bp_pkg::bp_update_t u);
        logic [`BP_INDEX_W-1:0] idx;
        logic [`BP_INDEX_W-1:0] hidx;
        bp_pkg::btb_entry_t     e;
        logic                   bim_t;
        logic                   hist_t;
        idx  = u.pc[IDX_LO +: `BP_INDEX_W];
        hidx = idx ^ ref_ghr;
        if (u.taken) begin
            e.valid    = 1'b1;
            e.tag      = u.pc[TAG_LO +: `BP_TAG_W];
            e.btype    = u.btype;
            e.target   = u.target;
            ref_btb[idx] = e;
        end
        if (u.btype == bp_pkg::BT_COND) begin
            bim_t  = ref_bim[idx] >= 2'd2;
            hist_t = ref_hist[hidx] >= 2'd2;
            if (bim_t != hist_t && hist_t == u.taken && ref_score < SCORE_HI) begin
                ref_score = ref_score + 1;
            end else if (bim_t != hist_t && bim_t == u.taken && ref_score > 0) begin
                ref_score = ref_score - 1;
            end
            ref_bim[idx]  = ctr_move(ref_bim[idx], u.taken);
            ref_hist[hidx] = ctr_move(ref_hist[hidx], u.taken);
            ref_ghr = {ref_ghr[`BP_INDEX_W-2:0], u.taken};
        end
    endfunction

    // expected prediction for a fetch address
    function automatic bp_pkg::bp_pred_t predict_next(input logic [31:0] pc);
        logic [`BP_INDEX_W-1:0] idx;
        bp_pkg::btb_entry_t     e;
        bp_pkg::bp_pred_t       p;
        logic                   hit;
        logic                   dir;
        idx = pc[IDX_LO +: `BP_INDEX_W];
        e   = ref_btb[idx];
        hit = e.valid && (e.tag == pc[TAG_LO +: `BP_TAG_W]);
        if (ref_score >= SCORE_MID) begin
            dir = ref_hist[idx ^ ref_ghr] >= 2'd2;
        end else begin
            dir = ref_bim[idx] >= 2'd2;
        end
        p.kind = bp_pkg::PK_NOT_TAKEN;
        if (hit && (e.btype == bp_pkg::BT_DIRECT || e.btype == bp_pkg::BT_INDIRECT)) begin
            p.kind = bp_pkg::PK_UNCOND;
        end else if (hit && e.btype == bp_pkg::BT_COND && dir) begin
            p.kind = bp_pkg::PK_COND;
        end
        if (p.kind != bp_pkg::PK_NOT_TAKEN) begin
            p.pc = e.target;
        end else begin
            p.pc = pc[2] ? pc + 32'd4 : pc + 32'd8;
        end
        return p;
    endfunction

    task automatic check_pred_pc(input logic [31:0] got, input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("error %0t: pred.pc %h, expected %h for fetch_pc %h",
                     $time, got, want, fetch_pc);
        end
    endtask

    task automatic check_kind(input bp_pkg::pred_kind_e got, input bp_pkg::pred_kind_e want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("error %0t: pred.kind %s, expected %s for fetch_pc %h",
                     $time, got.name(), want.name(), fetch_pc);
        end
    endtask

    function automatic bp_pkg::bp_update_t make_upd(input logic [31:0] pc,
                                                    input logic [31:0] tgt,
                                                    input bp_pkg::btype_e bt,
                                                    input logic tk);
        bp_pkg::bp_update_t u;
        u.valid  = 1'b1;
        u.pc     = pc;
        u.target = tgt;
        u.btype  = bt;
        u.taken  = tk;
        return u;
    endfunction

    // the four branch addresses of the random mix
    function automatic logic [31:0] mix_pc(input logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h0000_5000;
            2'd1:    return 32'h0000_5108;
            2'd2:    return 32'h0000_5210;
            default: return 32'h0000_6018;
        endcase
    endfunction

    task automatic drive_cycle(input logic [31:0] pc, input bp_pkg::bp_update_t u);
        @(posedge clk);
        fetch_pc <= pc;
        upd      <= u;
    endtask

    task automatic random_lookups(input int n);
        repeat (n) drive_cycle($random(seed), NO_UPD);
    endtask

    // model follows the DUT state at every sampling edge
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            reset_model();
        end else if (upd.valid) begin
            train_model(upd);
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        bp_pkg::bp_pred_t want;
        if (rstn === 1'b1) begin
            want = predict_next(fetch_pc);
            check_pred_pc(pred.pc, want.pc);
            check_kind(pred.kind, want.kind);
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] upd_pc;
        logic [31:0] look_pc;
        logic [5:0]  pattern;
        logic        alt;
        logic        tk;
        int          n_assert_fail;
        seed     = 32'h228a;
        n_errors = 0;
        n_checks = 0;
        rst_req  = 1'b0;
        fetch_pc = '0;
        upd      = '0;
        alt      = 1'b0;
        pattern  = 6'b110001;
        reset_model();
        wait (rstn === 1'b1);

        // after reset everything falls through
        random_lookups(N_LOOK);

        // direct and indirect taken branches
        drive_cycle(32'h0000_1010,
                    make_upd(32'h0000_1010, 32'h0000_4800, bp_pkg::BT_DIRECT, 1'b1));
        drive_cycle(32'h0000_2034,
                    make_upd(32'h0000_2034, 32'h0000_7ff0, bp_pkg::BT_INDIRECT, 1'b1));
        drive_cycle(32'h0000_1010, NO_UPD);
        drive_cycle(32'h0000_1014, NO_UPD);
        drive_cycle(32'h0000_2034, NO_UPD);

        // same index, other tag, then replacement
        drive_cycle(32'h0001_1010, NO_UPD);
        drive_cycle(32'h0001_1010, make_upd(32'h0001_1010, 32'h0000_9000, bp_pkg::BT_DIRECT, 1'b1));
        drive_cycle(32'h0001_1010, NO_UPD);
        drive_cycle(32'h0000_1010, NO_UPD);

        // conditional trained taken, not taken three times, taken twice
        for (int i = 0; i < 6; i++) begin
            drive_cycle(32'h0000_3048,
                        make_upd(32'h0000_3048, 32'h0000_3100, bp_pkg::BT_COND, pattern[i]));
            drive_cycle(32'h0000_3048, NO_UPD);
        end

        // random conditional mix, one always taken, one alternating
        for (int i = 0; i < N_MIX; i++) begin
            r       = $random(seed);
            upd_pc  = mix_pc(r[1:0]);
            look_pc = mix_pc(r[5:4]) | {29'b0, r[6], 2'b00};
            if (r[3:2] != 2'b00) begin
                tk = (r[1:0] == 2'd0) ? 1'b1 : (r[1:0] == 2'd1) ? alt : r[7];
                if (r[1:0] == 2'd1) begin
                    alt = !alt;
                end
                drive_cycle(look_pc, make_upd(upd_pc, upd_pc + 32'h400, bp_pkg::BT_COND, tk));
            end else begin
                drive_cycle(look_pc, NO_UPD);
            end
        end

        // reset in the middle of the run
        @(posedge clk);
        rst_req <= 1'b1;
        upd     <= NO_UPD;
        repeat (2) @(posedge clk);
        rst_req <= 1'b0;
        wait (rstn === 1'b1);
        random_lookups(N_LOOK);
        drive_cycle(32'h0, NO_UPD);
        @(posedge clk);

        n_assert_fail = u_branch_predictor.u_assert.n_fail;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, n_assert_fail);
        if (n_errors == 0 && n_assert_fail == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verification/tb_clock.sv
/*
 testbench clock and reset
 100 ns clock, reset held for the first 4 cycles and
 again whenever the testbench requests it
*/
`timescale 1ns/10ps

module tb_clock (
    input  logic rst_req,
    output logic clk,
    output logic rstn
);

    logic por_done;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // power-on reset released on the 4th rising edge
    initial begin
        por_done = 1'b0;
        repeat (4) @(posedge clk);
        por_done <= 1'b1;
    end

    assign rstn = por_done && !rst_req;

endmodule
